/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_mem_bus
FILELIST := compile.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
PASS_MSG := Done: no errors
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

/* compile.f */
hdl/axi_lite_pkg.sv
hdl/soc_map_pkg.sv
hdl/bus_arb_ctrl.sv
hdl/master_mux.sv
hdl/slave_router.sv
hdl/sram_slave.sv
hdl/uart_tx_slave.sv
hdl/mem_bus_top.sv
dv/tb_clk_gen.sv
dv/mem_bus_asserts.sv
dv/tb_mem_bus.sv

/* dv/mem_bus_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_bus_asserts
    import axi_lite_pkg::*;
    import soc_map_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input grant_t  grant,
    input rd_req_t bus_rd_req,
    input rd_rsp_t bus_rd_rsp,
    input wr_req_t bus_wr_req
);

    int fail_cnt = 0;  // failed assertions so far

    logic rd_granted;

    assign rd_granted = (grant == gnt_ifu_rd) || (grant == gnt_lsu_rd);

    // nothing reaches the slaves without an owner
    idle_bus_quiet: assert property (@(posedge clk) disable iff (rst)
        (grant == gnt_idle) |-> !bus_rd_req.ar_valid && !bus_wr_req.aw_valid
                                && !bus_wr_req.w_valid)
        else begin
            fail_cnt++;
            $error("bus request valid while no master holds the grant");
        end

    // one owner hands over only through idle
    grant_via_idle: assert property (@(posedge clk) disable iff (rst)
        (grant != gnt_idle) |=> (grant == $past(grant)) || (grant == gnt_idle))
        else begin
            fail_cnt++;
            $error("grant moved between two masters without passing idle");
        end

    rd_grant_held: assert property (@(posedge clk) disable iff (rst)
        rd_granted && bus_rd_rsp.r_valid && !bus_rd_req.r_ready |=> grant == $past(grant))
        else begin
            fail_cnt++;
            $error("read grant dropped while read data was stalled");
        end

endmodule

bind bus_arb_ctrl mem_bus_asserts u_mem_bus_asserts (
    .clk        (clk),
    .rst        (rst),
    .grant      (grant),
    .bus_rd_req (bus_rd_req),
    .bus_rd_rsp (bus_rd_rsp),
    .bus_wr_req (bus_wr_req)
);

`default_nettype wire

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    localparam real half_period = 20.0;  // 40 ns period

    initial begin
        clk = 1'b0;
        forever begin
            #(half_period) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* dv/tb_mem_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_bus
    import axi_lite_pkg::*;
    import soc_map_pkg::*;
();

    typedef enum logic [1:0] {
        op_none,
        op_rd,
        op_wr
    } lsu_op_t;

    typedef struct packed {
        logic       ifu_en;
        addr_t      ifu_addr;
        lsu_op_t    lsu_op;
        addr_t      lsu_addr;
        data_t      wdata;
        strb_t      strb;
        data_t      exp_ifu_data;
        data_t      exp_lsu_data;
        resp_t      exp_resp;     // applies to every response of the entry
        logic [1:0] exp_tx_cnt;
        uart_byte_t exp_tx_byte;
    } vec_t;

    localparam int n_vec      = 13;
    localparam int max_cycles = n_vec * 16 + 20;

    logic       clk;
    logic       rst;
    rd_req_t    ifu_rd_req;
    rd_rsp_t    ifu_rd_rsp;
    rd_req_t    lsu_rd_req;
    wr_req_t    lsu_wr_req;
    rd_rsp_t    lsu_rd_rsp;
    wr_rsp_t    lsu_wr_rsp;
    logic       tx_valid;
    uart_byte_t tx_data;

    vec_t  vec [n_vec];
    string vec_name [n_vec];
    int    errors    = 0;
    int    checks    = 0;
    int    cycle_cnt = 0;

    tb_clk_gen u_tb_clk_gen (
        .clk (clk)
    );

    mem_bus_top u_mem_bus_top (
        .clk        (clk),        .rst        (rst),
        .ifu_rd_req (ifu_rd_req), .ifu_rd_rsp (ifu_rd_rsp),
        .lsu_rd_req (lsu_rd_req), .lsu_wr_req (lsu_wr_req),
        .lsu_rd_rsp (lsu_rd_rsp), .lsu_wr_rsp (lsu_wr_rsp),
        .tx_valid   (tx_valid),   .tx_data    (tx_data)
    );

    task automatic load_vectors();
        // sram words at 0x10, 0x20 and 0x0 are built up across entries
        vec_name[0]  = "lsu_wr_sram";
        vec[0]  = '{1'b0, 32'h0, op_wr, 32'h8000_0010, 32'hdead_beef, 4'hf,
                    32'h0, 32'h0, resp_okay, 2'd0, 8'h00};
        vec_name[1]  = "lsu_rd_sram";
        vec[1]  = '{1'b0, 32'h0, op_rd, 32'h8000_0010, 32'h0, 4'h0,
                    32'h0, 32'hdead_beef, resp_okay, 2'd0, 8'h00};
        vec_name[2]  = "lsu_wr_partial";
        vec[2]  = '{1'b0, 32'h0, op_wr, 32'h8000_0010, 32'h1122_3344, 4'b0101,
                    32'h0, 32'h0, resp_okay, 2'd0, 8'h00};
        vec_name[3]  = "lsu_rd_partial";  // lanes 0 and 2 replaced
        vec[3]  = '{1'b0, 32'h0, op_rd, 32'h8000_0010, 32'h0, 4'h0,
                    32'h0, 32'hde22_be44, resp_okay, 2'd0, 8'h00};
        vec_name[4]  = "ifu_rd_with_lsu_wr";
        vec[4]  = '{1'b1, 32'h8000_0010, op_wr, 32'h8000_0020, 32'hcafe_f00d, 4'hf,
                    32'hde22_be44, 32'h0, resp_okay, 2'd0, 8'h00};
        vec_name[5]  = "ifu_rd_lsu_word";
        vec[5]  = '{1'b1, 32'h8000_0020, op_none, 32'h0, 32'h0, 4'h0,
                    32'hcafe_f00d, 32'h0, resp_okay, 2'd0, 8'h00};
        vec_name[6]  = "lsu_wr_base";
        vec[6]  = '{1'b0, 32'h0, op_wr, 32'h8000_0000, 32'h0bad_f00d, 4'hf,
                    32'h0, 32'h0, resp_okay, 2'd0, 8'h00};
        vec_name[7]  = "uart_tx_byte";
        vec[7]  = '{1'b0, 32'h0, op_wr, 32'ha000_03f8, 32'h0000_0041, 4'b0001,
                    32'h0, 32'h0, resp_okay, 2'd1, 8'h41};
        vec_name[8]  = "uart_no_lane0";
        vec[8]  = '{1'b0, 32'h0, op_wr, 32'ha000_03f8, 32'h0000_0055, 4'b1110,
                    32'h0, 32'h0, resp_okay, 2'd0, 8'h00};
        vec_name[9]  = "rd_unmapped";
        vec[9]  = '{1'b0, 32'h0, op_rd, 32'h4000_0000, 32'h0, 4'h0,
                    32'h0, 32'h0, resp_decerr, 2'd0, 8'h00};
        vec_name[10] = "rd_uart";
        vec[10] = '{1'b0, 32'h0, op_rd, 32'ha000_03f8, 32'h0, 4'h0,
                    32'h0, 32'h0, resp_decerr, 2'd0, 8'h00};
        vec_name[11] = "wr_unmapped";     // first word past the window
        vec[11] = '{1'b0, 32'h0, op_wr, 32'h8000_1000, 32'h1234_5678, 4'hf,
                    32'h0, 32'h0, resp_decerr, 2'd0, 8'h00};
        vec_name[12] = "rd_base_back";
        vec[12] = '{1'b0, 32'h0, op_rd, 32'h8000_0000, 32'h0, 4'h0,
                    32'h0, 32'h0bad_f00d, resp_okay, 2'd0, 8'h00};
    endtask

    task automatic check_val(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error: %s %s expected %h actual %h", name, what, exp, got);
        end
    endtask

    task automatic run_vec(input int i);
        vec_t       v;
        logic       ifu_wait;
        logic       lsu_wait;
        logic       ifu_ar_hs;
        logic       lsu_ar_hs;
        logic       lsu_wr_hs;
        int         ifu_done_at;
        int         lsu_done_at;
        int         tx_cnt;
        uart_byte_t tx_byte;
        data_t      ifu_data;
        resp_t      ifu_resp;
        data_t      lsu_data;
        resp_t      lsu_resp;
        v           = vec[i];
        ifu_wait    = v.ifu_en;
        lsu_wait    = (v.lsu_op != op_none);
        ifu_done_at = 0;
        lsu_done_at = 0;
        tx_cnt      = 0;
        tx_byte     = '0;
        ifu_data    = '0;
        ifu_resp    = '0;
        lsu_data    = '0;
        lsu_resp    = '0;

        @(posedge clk);
        ifu_rd_req <= '{ar_valid: v.ifu_en, ar_addr: v.ifu_addr, r_ready: 1'b1};
        lsu_rd_req <= '{ar_valid: (v.lsu_op == op_rd), ar_addr: v.lsu_addr, r_ready: 1'b1};
        lsu_wr_req <= '{aw_valid: (v.lsu_op == op_wr), aw_addr: v.lsu_addr,
                        w_valid: (v.lsu_op == op_wr), w_data: v.wdata,
                        w_strb: v.strb, b_ready: 1'b1};

        while (ifu_wait || lsu_wait) begin
            @(negedge clk);  // responses are settled here
            ifu_ar_hs = ifu_rd_req.ar_valid && ifu_rd_rsp.ar_ready;
            lsu_ar_hs = lsu_rd_req.ar_valid && lsu_rd_rsp.ar_ready;
            lsu_wr_hs = lsu_wr_req.aw_valid && lsu_wr_rsp.aw_ready
                     && lsu_wr_req.w_valid && lsu_wr_rsp.w_ready;
            if (tx_valid) begin
                tx_cnt++;
                tx_byte = tx_data;
            end
            if (ifu_wait && ifu_rd_rsp.r_valid) begin
                ifu_wait    = 1'b0;
                ifu_done_at = cycle_cnt;
                ifu_data    = ifu_rd_rsp.r_data;
                ifu_resp    = ifu_rd_rsp.r_resp;
            end
            if (lsu_wait && v.lsu_op == op_rd && lsu_rd_rsp.r_valid) begin
                lsu_wait    = 1'b0;
                lsu_done_at = cycle_cnt;
                lsu_data    = lsu_rd_rsp.r_data;
                lsu_resp    = lsu_rd_rsp.r_resp;
            end
            if (lsu_wait && v.lsu_op == op_wr && lsu_wr_rsp.b_valid) begin
                lsu_wait    = 1'b0;
                lsu_done_at = cycle_cnt;
                lsu_resp    = lsu_wr_rsp.b_resp;
            end
            @(posedge clk);
            if (ifu_ar_hs) begin
                ifu_rd_req.ar_valid <= 1'b0;
            end
            if (lsu_ar_hs) begin
                lsu_rd_req.ar_valid <= 1'b0;
            end
            if (lsu_wr_hs) begin
                lsu_wr_req.aw_valid <= 1'b0;
                lsu_wr_req.w_valid  <= 1'b0;
            end
        end

        if (v.ifu_en) begin
            check_val(vec_name[i], "ifu r_data", v.exp_ifu_data, ifu_data);
            check_val(vec_name[i], "ifu r_resp", 32'(v.exp_resp), 32'(ifu_resp));
        end
        if (v.lsu_op == op_rd) begin
            check_val(vec_name[i], "lsu r_data", v.exp_lsu_data, lsu_data);
        end
        if (v.lsu_op != op_none) begin
            check_val(vec_name[i], "lsu resp", 32'(v.exp_resp), 32'(lsu_resp));
        end
        check_val(vec_name[i], "tx pulses", 32'(v.exp_tx_cnt), tx_cnt);
        if (v.exp_tx_cnt != 0) begin
            check_val(vec_name[i], "tx byte", 32'(v.exp_tx_byte), 32'(tx_byte));
        end
        if (v.ifu_en && v.lsu_op != op_none) begin
            checks++;
            assert (ifu_done_at < lsu_done_at) else begin
                errors++;
                $display("%s: the lsu response came before the ifu read response",
                         vec_name[i]);
            end
        end
    endtask

    // run limit scales with the table length
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: no completion after %0d cycles, a response never arrived",
                     cycle_cnt);
            $display("errors: %0d in %0d checks", errors, checks);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        ifu_rd_req = '0;
        lsu_rd_req = '0;
        lsu_wr_req = '0;
        rst        = 1'b1;
        load_vectors();
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);  // quiet outputs right after reset
        check_val("reset", "ifu ready valid", 32'h0,
                  32'({ifu_rd_rsp.ar_ready, ifu_rd_rsp.r_valid}));
        check_val("reset", "lsu ready valid", 32'h0,
                  32'({lsu_rd_rsp.ar_ready, lsu_rd_rsp.r_valid}));
        check_val("reset", "lsu wr rsp", 32'h0, 32'(lsu_wr_rsp));
        check_val("reset", "tx_valid", 32'h0, 32'(tx_valid));

        for (int i = 0; i < n_vec; i++) begin
            run_vec(i);
        end
        repeat (2) @(posedge clk);

        errors += u_mem_bus_top.u_bus_arb_ctrl.u_mem_bus_asserts.fail_cnt;
        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/axi_lite_pkg.sv */
`default_nettype none

package axi_lite_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;  // one strobe bit per byte lane
    localparam int resp_w = 2;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [strb_w-1:0] strb_t;
    typedef logic [resp_w-1:0] resp_t;

    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_decerr = 2'b11;

    // read address and read data, master side
    typedef struct packed {
        logic  ar_valid;
        addr_t ar_addr;
        logic  r_ready;
    } rd_req_t;

    typedef struct packed {
        logic  ar_ready;
        logic  r_valid;
        data_t r_data;
        resp_t r_resp;
    } rd_rsp_t;

    // aw and w travel together, b comes back on its own
    typedef struct packed {
        logic  aw_valid;
        addr_t aw_addr;
        logic  w_valid;
        data_t w_data;
        strb_t w_strb;
        logic  b_ready;
    } wr_req_t;

    typedef struct packed {
        logic  aw_ready;
        logic  w_ready;
        logic  b_valid;
        resp_t b_resp;
    } wr_rsp_t;

endpackage

`default_nettype wire

/* hdl/bus_arb_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arb_ctrl
    import axi_lite_pkg::*;
    import soc_map_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  rd_req_t ifu_rd_req,
    input  rd_req_t lsu_rd_req,
    input  wr_req_t lsu_wr_req,
    input  rd_req_t bus_rd_req,
    input  rd_rsp_t bus_rd_rsp,
    input  wr_req_t bus_wr_req,
    input  wr_rsp_t bus_wr_rsp,
    output grant_t  grant
);

    grant_t grant_next;
    logic   ifu_rd_pend;
    logic   lsu_rd_pend;
    logic   lsu_wr_pend;
    logic   rd_done;
    logic   wr_done;

    // requests seen while idle
    assign ifu_rd_pend = ifu_rd_req.ar_valid;
    assign lsu_rd_pend = lsu_rd_req.ar_valid;
    assign lsu_wr_pend = lsu_wr_req.aw_valid && lsu_wr_req.w_valid;  // aw and w go together

    // end of transaction is the response handshake on the shared bus
    assign rd_done = bus_rd_rsp.r_valid && bus_rd_req.r_ready;
    assign wr_done = bus_wr_rsp.b_valid && bus_wr_req.b_ready;

    always_comb begin
        grant_next = grant;
        unique case (grant)
            gnt_idle: begin
                // fixed priority, ifu fetch wins
                if (ifu_rd_pend) begin
                    grant_next = gnt_ifu_rd;
                end else if (lsu_rd_pend) begin
                    grant_next = gnt_lsu_rd;
                end else if (lsu_wr_pend) begin
                    grant_next = gnt_lsu_wr;
                end
            end
            gnt_ifu_rd,
            gnt_lsu_rd: begin
                if (rd_done) begin
                    grant_next = gnt_idle;
                end
            end
            gnt_lsu_wr: begin
                if (wr_done) begin
                    grant_next = gnt_idle;
                end
            end
            default: begin
                grant_next = gnt_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= gnt_idle;
        end else begin
            grant <= grant_next;  // always passes through idle between owners
        end
    end

endmodule

`default_nettype wire

/* hdl/master_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module master_mux
    import axi_lite_pkg::*;
    import soc_map_pkg::*;
(
    input  grant_t  grant,
    input  rd_req_t ifu_rd_req,
    input  rd_req_t lsu_rd_req,
    input  wr_req_t lsu_wr_req,
    output rd_rsp_t ifu_rd_rsp,
    output rd_rsp_t lsu_rd_rsp,
    output wr_rsp_t lsu_wr_rsp,
    output rd_req_t bus_rd_req,
    output wr_req_t bus_wr_req,
    input  rd_rsp_t bus_rd_rsp,
    input  wr_rsp_t bus_wr_rsp
);

    always_comb begin
        // nothing reaches the bus unless granted
        bus_rd_req = '0;
        bus_wr_req = '0;
        ifu_rd_rsp = '0;
        lsu_rd_rsp = '0;
        lsu_wr_rsp = '0;

        unique case (grant)
            gnt_ifu_rd: begin
                bus_rd_req = ifu_rd_req;
                ifu_rd_rsp = bus_rd_rsp;
            end
            gnt_lsu_rd: begin
                bus_rd_req = lsu_rd_req;
                lsu_rd_rsp = bus_rd_rsp;
            end
            gnt_lsu_wr: begin
                bus_wr_req = lsu_wr_req;
                lsu_wr_rsp = bus_wr_rsp;
            end
            default: begin
                // idle keeps every valid and ready low
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/mem_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_bus_top
    import axi_lite_pkg::*;
    import soc_map_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  rd_req_t    ifu_rd_req,
    output rd_rsp_t    ifu_rd_rsp,
    input  rd_req_t    lsu_rd_req,
    input  wr_req_t    lsu_wr_req,
    output rd_rsp_t    lsu_rd_rsp,
    output wr_rsp_t    lsu_wr_rsp,
    output logic       tx_valid,
    output uart_byte_t tx_data
);

    grant_t  grant;
    rd_req_t bus_rd_req;
    rd_rsp_t bus_rd_rsp;
    wr_req_t bus_wr_req;
    wr_rsp_t bus_wr_rsp;
    rd_req_t sram_rd_req;
    rd_rsp_t sram_rd_rsp;
    wr_req_t sram_wr_req;
    wr_rsp_t sram_wr_rsp;
    wr_req_t uart_wr_req;
    wr_rsp_t uart_wr_rsp;

    bus_arb_ctrl u_bus_arb_ctrl (
        .clk        (clk),        .rst        (rst),
        .ifu_rd_req (ifu_rd_req), .lsu_rd_req (lsu_rd_req), .lsu_wr_req (lsu_wr_req),
        .bus_rd_req (bus_rd_req), .bus_rd_rsp (bus_rd_rsp),
        .bus_wr_req (bus_wr_req), .bus_wr_rsp (bus_wr_rsp),
        .grant      (grant)
    );

    master_mux u_master_mux (
        .grant      (grant),
        .ifu_rd_req (ifu_rd_req), .lsu_rd_req (lsu_rd_req), .lsu_wr_req (lsu_wr_req),
        .ifu_rd_rsp (ifu_rd_rsp), .lsu_rd_rsp (lsu_rd_rsp), .lsu_wr_rsp (lsu_wr_rsp),
        .bus_rd_req (bus_rd_req), .bus_wr_req (bus_wr_req),
        .bus_rd_rsp (bus_rd_rsp), .bus_wr_rsp (bus_wr_rsp)
    );

    slave_router u_slave_router (
        .clk         (clk),         .rst         (rst),
        .bus_rd_req  (bus_rd_req),  .bus_wr_req  (bus_wr_req),
        .bus_rd_rsp  (bus_rd_rsp),  .bus_wr_rsp  (bus_wr_rsp),
        .sram_rd_req (sram_rd_req), .sram_rd_rsp (sram_rd_rsp),
        .sram_wr_req (sram_wr_req), .sram_wr_rsp (sram_wr_rsp),
        .uart_wr_req (uart_wr_req), .uart_wr_rsp (uart_wr_rsp)
    );

    sram_slave u_sram_slave (
        .clk    (clk),         .rst    (rst),
        .rd_req (sram_rd_req), .rd_rsp (sram_rd_rsp),
        .wr_req (sram_wr_req), .wr_rsp (sram_wr_rsp)
    );

    uart_tx_slave u_uart_tx_slave (
        .clk      (clk),         .rst    (rst),
        .wr_req   (uart_wr_req), .wr_rsp (uart_wr_rsp),
        .tx_valid (tx_valid),    .tx_data (tx_data)
    );

endmodule

`default_nettype wire

/* hdl/slave_router.sv */
`timescale 1ns/1ps
`default_nettype none

module slave_router
    import axi_lite_pkg::*;
    import soc_map_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  rd_req_t bus_rd_req,
    input  wr_req_t bus_wr_req,
    output rd_rsp_t bus_rd_rsp,
    output wr_rsp_t bus_wr_rsp,
    output rd_req_t sram_rd_req,
    input  rd_rsp_t sram_rd_rsp,
    output wr_req_t sram_wr_req,
    input  wr_rsp_t sram_wr_rsp,
    output wr_req_t uart_wr_req,
    input  wr_rsp_t uart_wr_rsp
);

    logic rd_busy;      // read accepted, response owed
    logic rd_sel_sram;
    logic wr_busy;
    logic wr_sel_sram;
    logic wr_sel_uart;
    logic rd_dec_sram;
    logic wr_dec_sram;
    logic wr_dec_uart;
    logic ar_hs;
    logic r_hs;
    logic wr_hs;
    logic b_hs;

    function automatic logic in_sram(addr_t addr);
        return (addr >= sram_base) && (addr < sram_base + sram_bytes);
    endfunction

    assign rd_dec_sram = in_sram(bus_rd_req.ar_addr);
    assign wr_dec_sram = in_sram(bus_wr_req.aw_addr);
    assign wr_dec_uart = (bus_wr_req.aw_addr == uart_data_addr);

    assign ar_hs = bus_rd_req.ar_valid && bus_rd_rsp.ar_ready;
    assign r_hs  = bus_rd_rsp.r_valid && bus_rd_req.r_ready;
    assign wr_hs = bus_wr_req.aw_valid && bus_wr_rsp.aw_ready
                && bus_wr_req.w_valid && bus_wr_rsp.w_ready;
    assign b_hs  = bus_wr_rsp.b_valid && bus_wr_req.b_ready;

    // read path, uart reads fall into the decode error branch
    always_comb begin
        sram_rd_req          = bus_rd_req;
        sram_rd_req.ar_valid = bus_rd_req.ar_valid && rd_dec_sram && !rd_busy;
        sram_rd_req.r_ready  = bus_rd_req.r_ready && rd_busy && rd_sel_sram;

        bus_rd_rsp = '0;
        if (!rd_busy) begin
            bus_rd_rsp.ar_ready = rd_dec_sram ? sram_rd_rsp.ar_ready : 1'b1;
        end else if (rd_sel_sram) begin
            bus_rd_rsp.r_valid = sram_rd_rsp.r_valid;
            bus_rd_rsp.r_data  = sram_rd_rsp.r_data;
            bus_rd_rsp.r_resp  = sram_rd_rsp.r_resp;
        end else begin
            bus_rd_rsp.r_valid = 1'b1;          // r_data stays zero
            bus_rd_rsp.r_resp  = resp_decerr;
        end
    end

    always_comb begin
        sram_wr_req          = bus_wr_req;
        sram_wr_req.aw_valid = bus_wr_req.aw_valid && wr_dec_sram && !wr_busy;
        sram_wr_req.w_valid  = bus_wr_req.w_valid && wr_dec_sram && !wr_busy;
        sram_wr_req.b_ready  = bus_wr_req.b_ready && wr_busy && wr_sel_sram;
        uart_wr_req          = bus_wr_req;
        uart_wr_req.aw_valid = bus_wr_req.aw_valid && wr_dec_uart && !wr_busy;
        uart_wr_req.w_valid  = bus_wr_req.w_valid && wr_dec_uart && !wr_busy;
        uart_wr_req.b_ready  = bus_wr_req.b_ready && wr_busy && wr_sel_uart;

        bus_wr_rsp = '0;
        if (!wr_busy) begin
            if (wr_dec_sram) begin
                bus_wr_rsp.aw_ready = sram_wr_rsp.aw_ready;
                bus_wr_rsp.w_ready  = sram_wr_rsp.w_ready;
            end else if (wr_dec_uart) begin
                bus_wr_rsp.aw_ready = uart_wr_rsp.aw_ready;
                bus_wr_rsp.w_ready  = uart_wr_rsp.w_ready;
            end else begin
                // unmapped, swallow aw and w in the same cycle
                bus_wr_rsp.aw_ready = bus_wr_req.aw_valid && bus_wr_req.w_valid;
                bus_wr_rsp.w_ready  = bus_wr_req.aw_valid && bus_wr_req.w_valid;
            end
        end else if (wr_sel_sram) begin
            bus_wr_rsp.b_valid = sram_wr_rsp.b_valid;
            bus_wr_rsp.b_resp  = sram_wr_rsp.b_resp;
        end else if (wr_sel_uart) begin
            bus_wr_rsp.b_valid = uart_wr_rsp.b_valid;
            bus_wr_rsp.b_resp  = uart_wr_rsp.b_resp;
        end else begin
            bus_wr_rsp.b_valid = 1'b1;
            bus_wr_rsp.b_resp  = resp_decerr;
        end
    end

    // target is latched at the address handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy     <= 1'b0;
            rd_sel_sram <= 1'b0;
            wr_busy     <= 1'b0;
            wr_sel_sram <= 1'b0;
            wr_sel_uart <= 1'b0;
        end else begin
            if (ar_hs) begin
                rd_busy     <= 1'b1;
                rd_sel_sram <= rd_dec_sram;
            end else if (r_hs) begin
                rd_busy <= 1'b0;
            end
            if (wr_hs) begin
                wr_busy     <= 1'b1;
                wr_sel_sram <= wr_dec_sram;
                wr_sel_uart <= wr_dec_uart;
            end else if (b_hs) begin
                wr_busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/soc_map_pkg.sv */
`default_nettype none

package soc_map_pkg;

    // sram window, word addressed inside
    localparam logic [31:0] sram_base  = 32'h8000_0000;
    localparam int          sram_words = 1024;
    localparam int          sram_idx_w = $clog2(sram_words);
    localparam logic [31:0] sram_bytes = 32'(sram_words * 4);

    typedef logic [sram_idx_w-1:0] sram_idx_t;

    localparam logic [31:0] uart_data_addr = 32'ha00003f8;  // tx data register
    localparam int          uart_byte_w    = 8;

    typedef logic [uart_byte_w-1:0] uart_byte_t;

    // which master owns the shared bus
    typedef enum logic [1:0] {
        gnt_idle,
        gnt_ifu_rd,
        gnt_lsu_rd,
        gnt_lsu_wr
    } grant_t;

endpackage

`default_nettype wire

/* hdl/sram_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_slave
    import axi_lite_pkg::*;
    import soc_map_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  rd_req_t rd_req,
    output rd_rsp_t rd_rsp,
    input  wr_req_t wr_req,
    output wr_rsp_t wr_rsp
);

    data_t     mem [sram_words];
    data_t     r_data_q;
    logic      r_pend;      // read data waiting for r_ready
    logic      b_pend;
    logic      ar_hs;
    logic      wr_hs;
    sram_idx_t rd_idx;
    sram_idx_t wr_idx;

    // word offset inside the window
    function automatic sram_idx_t word_idx(addr_t addr);
        addr_t offset;
        offset = addr - sram_base;
        return offset[2 +: sram_idx_w];
    endfunction

    assign rd_idx = word_idx(rd_req.ar_addr);
    assign wr_idx = word_idx(wr_req.aw_addr);

    assign ar_hs = rd_req.ar_valid && !r_pend;
    assign wr_hs = wr_req.aw_valid && wr_req.w_valid && !b_pend;

    always_comb begin
        rd_rsp.ar_ready = !r_pend;
        rd_rsp.r_valid  = r_pend;
        rd_rsp.r_data   = r_data_q;
        rd_rsp.r_resp   = resp_okay;

        wr_rsp.aw_ready = wr_hs;   // both channels accepted together
        wr_rsp.w_ready  = wr_hs;
        wr_rsp.b_valid  = b_pend;
        wr_rsp.b_resp   = resp_okay;
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            for (int i = 0; i < strb_w; i++) begin
                if (wr_req.w_strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wr_req.w_data[8*i +: 8];
                end
            end
        end
        if (ar_hs) begin
            r_data_q <= mem[rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_pend <= 1'b0;
            b_pend <= 1'b0;
        end else begin
            if (ar_hs) begin
                r_pend <= 1'b1;
            end else if (r_pend && rd_req.r_ready) begin
                r_pend <= 1'b0;
            end
            if (wr_hs) begin
                b_pend <= 1'b1;
            end else if (b_pend && wr_req.b_ready) begin
                b_pend <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/uart_tx_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_slave
    import axi_lite_pkg::*;
    import soc_map_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  wr_req_t    wr_req,
    output wr_rsp_t    wr_rsp,
    output logic       tx_valid,
    output uart_byte_t tx_data
);

    logic b_pend;   // okay response owed
    logic wr_hs;

    assign wr_hs = wr_req.aw_valid && wr_req.w_valid && !b_pend;

    // byte leaves on the handshake cycle itself
    assign tx_valid = wr_hs && wr_req.w_strb[0];
    assign tx_data  = wr_req.w_data[uart_byte_w-1:0];

    always_comb begin
        wr_rsp.aw_ready = wr_hs;
        wr_rsp.w_ready  = wr_hs;
        wr_rsp.b_valid  = b_pend;
        wr_rsp.b_resp   = resp_okay;  // acked even with lane 0 off
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            b_pend <= 1'b0;
        end else if (wr_hs) begin
            b_pend <= 1'b1;
        end else if (b_pend && wr_req.b_ready) begin
            b_pend <= 1'b0;
        end
    end

endmodule

`default_nettype wire
